// File: logic/hello_pkg.sv
/*
 * Hello-world register block shared definitions
 * Bus widths, register map and fixed response values
 */

package hello_pkg;

  //----------------------------------------------------------------------
  // Widths
  //----------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned RESP_WIDTH = 2;
  localparam int unsigned LED_WIDTH  = 16;

  // OCL byte address
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Register data word
  typedef logic [DATA_WIDTH-1:0] data_t;
  // Write byte strobes
  typedef logic [STRB_WIDTH-1:0] strb_t;
  // AXI response code
  typedef logic [RESP_WIDTH-1:0] resp_t;
  // Virtual LED and DIP switch vectors
  typedef logic [LED_WIDTH-1:0]  led_t;

  //----------------------------------------------------------------------
  // Register map and constants
  //----------------------------------------------------------------------
  localparam resp_t RESP_OKAY = 2'b00;

  localparam addr_t HELLO_WORLD_REG_ADDR = 32'h0000_0500;
  localparam addr_t VLED_REG_ADDR        = 32'h0000_0504;

  // Returned for any address outside the map
  localparam data_t UNIMPLEMENTED_REG_VALUE = 32'hDEAD_DEAD;

endpackage

// File: logic/reg_access_if.sv
/*
 * Register access link
 * Carries write pulses and read lookups from the OCL slave to the
 * register block
 */

`timescale 1ns/1ps

interface reg_access_if import hello_pkg::*; ();

  // Write side, one pulse per accepted data beat
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // Read side, combinational lookup
  addr_t rd_addr;
  data_t rd_data;

  modport slave (
    output wr_en, wr_addr, wr_data, rd_addr,
    input  rd_data
  );

  modport regs (
    input  wr_en, wr_addr, wr_data, rd_addr,
    output rd_data
  );

endinterface

// File: logic/ocl_slave.sv
/*
 * OCL AXI-Lite slave
 * Single-beat accesses only, one outstanding write and one outstanding
 * read, every response OKAY
 */

`timescale 1ns/1ps

module ocl_slave import hello_pkg::*; (
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,

  input  logic  awvalid,
  input  addr_t awaddr,
  output logic  awready,

  input  logic  wvalid,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  wready,

  output logic  bvalid,
  output resp_t bresp,
  input  logic  bready,

  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,

  output logic  rvalid,
  output data_t rdata,
  output resp_t rresp,
  input  logic  rready,

  reg_access_if.slave regs_if
);

  logic  wr_active;
  addr_t wr_addr_q;
  logic  rd_pending;
  addr_t rd_addr_q;

  logic  aw_hs;
  logic  w_hs;
  logic  ar_hs;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign ar_hs = arvalid && arready;

  //----------------------------------------------------------------------
  // Write channel
  //----------------------------------------------------------------------
  assign awready = !wr_active;
  // Data phase closes once the response is raised
  assign wready  = wr_active && wvalid && !bvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && bready) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= awaddr;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (w_hs) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = RESP_OKAY;

  // Byte strobes are accepted but every write is a full word
  assign regs_if.wr_en   = w_hs;
  assign regs_if.wr_addr = wr_addr_q;
  assign regs_if.wr_data = wdata;

  //----------------------------------------------------------------------
  // Read channel
  //----------------------------------------------------------------------
  assign arready = !rd_pending && !rvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= ar_hs;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= araddr;
    end
  end

  assign regs_if.rd_addr = rd_addr_q;

  // Lookup result is sampled one cycle after the address is captured
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (rd_pending) begin
      rvalid <= 1'b1;
      rdata  <= regs_if.rd_data;
      rresp  <= RESP_OKAY;
    end
  end

endmodule

// File: logic/hello_regs.sv
/*
 * Hello-world and virtual LED registers
 * Hello-world reads back byte-swapped, the LED register shadows its
 * low half
 */

`timescale 1ns/1ps

module hello_regs import hello_pkg::*; (
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,

  reg_access_if.regs regs_if,

  output led_t  shadow_leds
);

  data_t hello_world_q;
  data_t hello_world_swapped;
  led_t  vled_q;

  //----------------------------------------------------------------------
  // Hello-world register
  //----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
    end else if (regs_if.wr_en && (regs_if.wr_addr == HELLO_WORLD_REG_ADDR)) begin
      hello_world_q <= regs_if.wr_data;
    end
  end

  // Byte order reversed on read
  assign hello_world_swapped = {hello_world_q[7:0],
                                hello_world_q[15:8],
                                hello_world_q[23:16],
                                hello_world_q[31:24]};

  //----------------------------------------------------------------------
  // Virtual LED shadow
  //----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_world_q[LED_WIDTH-1:0];
    end
  end

  assign shadow_leds = vled_q;

  // Read mux
  always_comb begin
    case (regs_if.rd_addr)
      HELLO_WORLD_REG_ADDR: begin
        regs_if.rd_data = hello_world_swapped;
      end
      VLED_REG_ADDR: begin
        regs_if.rd_data = data_t'(vled_q);
      end
      default: begin
        regs_if.rd_data = UNIMPLEMENTED_REG_VALUE;
      end
    endcase
  end

endmodule

// File: logic/vled_ctrl.sv
/*
 * Virtual LED output
 * Synchronizes the DIP switches and masks the shadow LEDs with them
 */

`timescale 1ns/1ps

module vled_ctrl import hello_pkg::*; #(
  parameter int unsigned VDIP_SYNC_STAGES = 2
) (
  input  logic clk_main_a0,
  input  logic rst_main_n_sync,

  input  led_t shadow_leds,
  input  led_t vdip_in,

  output led_t led_out
);

  led_t sync_q [VDIP_SYNC_STAGES];
  led_t vdip_sync;

  // DIP switch synchronizer chain
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      for (int i = 0; i < VDIP_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= vdip_in;
      for (int i = 1; i < VDIP_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign vdip_sync = sync_q[VDIP_SYNC_STAGES-1];

  // Switch off means LED off
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_out <= '0;
    end else begin
      led_out <= shadow_leds & vdip_sync;
    end
  end

endmodule

// File: logic/cl_hello_world.sv
/*
 * Hello-world custom logic top
 * OCL register slave, hello-world registers and virtual LED output
 */

`timescale 1ns/1ps

module cl_hello_world import hello_pkg::*; #(
  parameter int unsigned VDIP_SYNC_STAGES = 2
) (
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,

  // OCL write address
  input  logic  awvalid,
  input  addr_t awaddr,
  output logic  awready,

  // OCL write data
  input  logic  wvalid,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  wready,

  // OCL write response
  output logic  bvalid,
  output resp_t bresp,
  input  logic  bready,

  // OCL read address
  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,

  // OCL read data
  output logic  rvalid,
  output data_t rdata,
  output resp_t rresp,
  input  logic  rready,

  input  led_t  vdip_in,
  output led_t  led_out
);

  reg_access_if regs_if ();

  led_t shadow_leds;

  //----------------------------------------------------------------------
  // Bus slave
  //----------------------------------------------------------------------
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .regs_if         (regs_if.slave)
  );

  //----------------------------------------------------------------------
  // Registers and LED path
  //----------------------------------------------------------------------
  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .regs_if         (regs_if.regs),
    .shadow_leds     (shadow_leds)
  );

  vled_ctrl #(
    .VDIP_SYNC_STAGES (VDIP_SYNC_STAGES)
  ) u_vled_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .shadow_leds     (shadow_leds),
    .vdip_in         (vdip_in),
    .led_out         (led_out)
  );

endmodule

// File: tests/hello_sva.sv
/*
 * OCL slave handshake assertions
 * Response hold rules and single outstanding write, bound into ocl_slave
 */

`timescale 1ns/1ps

module hello_sva import hello_pkg::*; (
  input logic  clk_main_a0,
  input logic  rst_main_n_sync,
  input logic  awvalid,
  input logic  awready,
  input logic  bvalid,
  input logic  bready,
  input logic  rvalid,
  input logic  rready,
  input data_t rdata
);

  // Write response stays up until taken
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read response and its data stay put until taken
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // No second address from the AW handshake until the B handshake
  aw_blocked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ((awvalid && awready) || (!awready && !(bvalid && bready))) |=> !awready)
    else $error("awready high while a write is pending");

endmodule

bind ocl_slave hello_sva u_hello_sva (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .awvalid         (awvalid),
  .awready         (awready),
  .bvalid          (bvalid),
  .bready          (bready),
  .rvalid          (rvalid),
  .rready          (rready),
  .rdata           (rdata)
);

// File: tests/hello_checker.sv
/*
 * Hello-world reference model and checker
 * Watches the top-level ports, models the registers and LED path and
 * compares every read response and every settled led_out value
 */

`timescale 1ns/1ps

module hello_checker import hello_pkg::*; #(
  parameter int unsigned VDIP_SYNC_STAGES = 2
) (
  input logic  clk_main_a0,
  input logic  rst_main_n_sync,
  input logic  awvalid,
  input logic  awready,
  input addr_t awaddr,
  input logic  wvalid,
  input logic  wready,
  input data_t wdata,
  input logic  bvalid,
  input logic  bready,
  input resp_t bresp,
  input logic  arvalid,
  input logic  arready,
  input addr_t araddr,
  input logic  rvalid,
  input logic  rready,
  input data_t rdata,
  input resp_t rresp,
  input led_t  vdip_in,
  input led_t  led_out
);

  // Cycles from the event to a stable led_out, counted on falling edges
  localparam int unsigned SETTLE = (VDIP_SYNC_STAGES + 1 > 3) ? VDIP_SYNC_STAGES + 1 : 3;

  data_t       hello_model = '0;
  led_t        dip_model   = '0;
  addr_t       aw_addr_q   = '0;
  addr_t       ar_addr_q   = '0;
  int unsigned settle_cnt  = SETTLE + 1;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  int unsigned read_count  = 0;

  function automatic data_t expected_read(input addr_t addr);
    data_t v;
    if (addr == HELLO_WORLD_REG_ADDR) begin
      // Byte b of the answer is byte 3-b of the register
      for (int b = 0; b < 4; b++) begin
        v[8*b +: 8] = hello_model[8*(3-b) +: 8];
      end
    end else if (addr == VLED_REG_ADDR) begin
      v = {16'h0000, hello_model[15:0]};
    end else begin
      v = UNIMPLEMENTED_REG_VALUE;
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end else begin
      $display("ok t=%0t %s = %h", $time, name, got);
    end
  endtask

  //----------------------------------------------------------------------
  // Inputs only change just after a rising edge, so the falling edge
  // sees the same values as the next handshake edge
  //----------------------------------------------------------------------
  always @(negedge clk_main_a0) begin
    if (rst_main_n_sync) begin
      if (settle_cnt <= SETTLE) begin
        settle_cnt++;
      end
      if (awvalid && awready) begin
        aw_addr_q = awaddr;
      end
      if (wvalid && wready && (aw_addr_q == HELLO_WORLD_REG_ADDR)) begin
        hello_model = wdata;
        settle_cnt  = 0;
      end
      if (bvalid && bready) begin
        compare("bresp", 32'(bresp), 32'(RESP_OKAY));
      end
      if (arvalid && arready) begin
        ar_addr_q = araddr;
      end
      if (rvalid && rready) begin
        read_count++;
        compare("rdata", rdata, expected_read(ar_addr_q));
        compare("rresp", 32'(rresp), 32'(RESP_OKAY));
      end
      if (vdip_in != dip_model) begin
        dip_model  = vdip_in;
        settle_cnt = 0;
      end
      if (settle_cnt == SETTLE) begin
        compare("led_out", 32'(led_out), 32'(hello_model[15:0] & dip_model));
      end
    end
  end

endmodule

// File: tests/tb_hello_world.sv
/*
 * Hello-world testbench
 * Applies a table of OCL writes, reads and DIP settings to the DUT,
 * then reports the checker's counts
 */

`timescale 1ns/1ps

module tb_hello_world import hello_pkg::*; ();

  localparam int unsigned VDIP_SYNC_STAGES = 2;
  localparam realtime     CLK_PERIOD       = 4.0;
  localparam int unsigned ENTRY_CYCLES     = 40;
  localparam int unsigned MARGIN_CYCLES    = 200;
  localparam int unsigned RANDOM_PAIRS     = 8;

  localparam int unsigned OP_WRITE = 0;
  localparam int unsigned OP_READ  = 1;
  localparam int unsigned OP_DIP   = 2;

  typedef struct {
    int unsigned op;
    addr_t       addr;
    data_t       data;
    int unsigned stall;
  } entry_t;

  logic  clk_main_a0 = 1'b0;
  logic  rst_main_n_sync;
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  strb_t wstrb;
  resp_t bresp, rresp;
  led_t  vdip_in, led_out;

  entry_t      stim_q[$];
  logic [31:0] lfsr_state = 32'hd8d55d40;

  always #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;

  cl_hello_world #(.VDIP_SYNC_STAGES(VDIP_SYNC_STAGES)) u_dut (.*);

  hello_checker #(.VDIP_SYNC_STAGES(VDIP_SYNC_STAGES)) u_check (.*);

  //----------------------------------------------------------------------
  // Random source
  //----------------------------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic add_entry(input int unsigned op, input addr_t addr, input data_t data,
                           input int unsigned stall);
    entry_t e;
    e.op    = op;
    e.addr  = addr;
    e.data  = data;
    e.stall = stall;
    stim_q.push_back(e);
  endtask

  //----------------------------------------------------------------------
  // Bus driving
  //----------------------------------------------------------------------
  task automatic next_drive();
    @(posedge clk_main_a0);
    #0.5;
  endtask

  task automatic ocl_write(input addr_t addr, input data_t data, input int unsigned stall);
    awvalid = 1'b1;
    awaddr  = addr;
    @(negedge clk_main_a0);
    while (!awready) @(negedge clk_main_a0);
    next_drive();
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = '1;
    @(negedge clk_main_a0);
    while (!wready) @(negedge clk_main_a0);
    next_drive();
    wvalid = 1'b0;
    // Hold off the response for a while
    repeat (stall) next_drive();
    bready = 1'b1;
    @(negedge clk_main_a0);
    while (!bvalid) @(negedge clk_main_a0);
    next_drive();
    bready = 1'b0;
  endtask

  task automatic ocl_read(input addr_t addr, input int unsigned stall);
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk_main_a0);
    while (!arready) @(negedge clk_main_a0);
    next_drive();
    arvalid = 1'b0;
    repeat (stall) next_drive();
    rready = 1'b1;
    @(negedge clk_main_a0);
    while (!rvalid) @(negedge clk_main_a0);
    next_drive();
    rready = 1'b0;
  endtask

  initial begin
    logic [31:0] b_addr, b_data, b_stall;
    int unsigned expected_reads;
    realtime     limit;

    rst_main_n_sync = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    vdip_in = '1;

    // Directed part, all switches on at first
    add_entry(OP_WRITE, HELLO_WORLD_REG_ADDR, 32'h1234_5678, 0);
    add_entry(OP_READ,  HELLO_WORLD_REG_ADDR, '0, 0);
    add_entry(OP_READ,  VLED_REG_ADDR,        '0, 0);
    add_entry(OP_READ,  32'h0000_0508,        '0, 0);
    add_entry(OP_WRITE, 32'h0000_0600,        32'hFFFF_FFFF, 0);
    add_entry(OP_WRITE, VLED_REG_ADDR,        32'h0BAD_0BAD, 0);
    add_entry(OP_READ,  HELLO_WORLD_REG_ADDR, '0, 0);
    add_entry(OP_READ,  VLED_REG_ADDR,        '0, 1);
    add_entry(OP_DIP,   '0,                   32'h0000_00F0, 0);
    add_entry(OP_WRITE, HELLO_WORLD_REG_ADDR, 32'hCAFE_A5A5, 4);
    add_entry(OP_READ,  HELLO_WORLD_REG_ADDR, '0, 5);
    add_entry(OP_DIP,   '0,                   32'h0000_FF0F, 0);
    add_entry(OP_READ,  32'h0000_0000,        '0, 2);

    // Random write/read pairs over both registers
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      take_bits(1, b_addr);
      take_bits(32, b_data);
      take_bits(2, b_stall);
      add_entry(OP_WRITE, b_addr[0] ? VLED_REG_ADDR : HELLO_WORLD_REG_ADDR, b_data, b_stall);
      take_bits(1, b_addr);
      take_bits(2, b_stall);
      add_entry(OP_READ, b_addr[0] ? VLED_REG_ADDR : HELLO_WORLD_REG_ADDR, '0, b_stall);
    end

    expected_reads = 0;
    foreach (stim_q[i]) begin
      if (stim_q[i].op == OP_READ) begin
        expected_reads++;
      end
    end

    limit = (stim_q.size() * ENTRY_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
    fork
      begin
        #(limit);
        $display("ERROR: watchdog expired after %0t, a handshake never completed", $time);
        $display("TEST FAILED");
        $finish;
      end
    join_none

    repeat (10) next_drive();
    rst_main_n_sync = 1'b1;
    repeat (2) next_drive();

    foreach (stim_q[i]) begin
      case (stim_q[i].op)
        OP_WRITE: ocl_write(stim_q[i].addr, stim_q[i].data, stim_q[i].stall);
        OP_READ:  ocl_read(stim_q[i].addr, stim_q[i].stall);
        default: begin
          vdip_in = stim_q[i].data[15:0];
          repeat (VDIP_SYNC_STAGES + 4) next_drive();
        end
      endcase
    end

    // Let the last LED value settle and be checked
    repeat (10) next_drive();

    if (u_check.read_count != expected_reads) begin
      $display("ERROR: checker saw %0d read responses, the table issued %0d",
               u_check.read_count, expected_reads);
    end
    $display("checks=%0d errors=%0d reads=%0d", u_check.check_count,
             u_check.error_count, u_check.read_count);
    if (u_check.error_count == 0 && u_check.read_count == expected_reads) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/hello_pkg.sv
logic/reg_access_if.sv
logic/ocl_slave.sv
logic/hello_regs.sv
logic/vled_ctrl.sv
logic/cl_hello_world.sv
tests/hello_sva.sv
tests/hello_checker.sv
tests/tb_hello_world.sv
